// ==== design/backendPkg.sv ====
// Shared word types, write-back select codes, sizes and stage bundles, referenced by scoped name.

package backendPkg;

   // ==========================================================================
   // sizes
   // ==========================================================================

   localparam int wordBits = 16;

   // data memory depth in words.
   localparam int memWords = 256;
   // low aluFinal bits that address a word.
   localparam int memAddrBits = 8;

   localparam int numRegs = 8;
   localparam int regIdxBits = $clog2(numRegs);

   // ==========================================================================
   // scalar types
   // ==========================================================================

   typedef logic [wordBits-1:0] word_t;
   typedef logic [regIdxBits-1:0] regIdx_t;

   // write-back source select.
   typedef enum logic [1:0] {
      wbSelMem = 2'b00,
      wbSelAlu = 2'b01,
      wbSelPc  = 2'b10,
      wbSelImm = 2'b11
   } wbSel_t;

   // ==========================================================================
   // stage bundles
   // ==========================================================================

   // execute to memory.
   typedef struct packed {
      logic    valid;
      word_t   instruction;
      word_t   newPC;
      logic    branchInst;
      word_t   aluFinal;
      word_t   storeData;
      logic    memRead;
      logic    memWrite;
      wbSel_t  wbDataSel;
      word_t   addPC;
      word_t   imm8;
      logic    regWrt;
      regIdx_t wrtReg;
   } exMemBundle_t;

   // memory to write-back, load data replaces the store controls.
   typedef struct packed {
      logic    valid;
      word_t   instruction;
      word_t   newPC;
      logic    branchInst;
      word_t   aluFinal;
      word_t   memOut;
      wbSel_t  wbDataSel;
      word_t   addPC;
      word_t   imm8;
      logic    regWrt;
      regIdx_t wrtReg;
   } memWbBundle_t;

   // retiring instruction as seen at write-back.
   typedef struct packed {
      logic    valid;
      word_t   instruction;
      word_t   newPC;
      logic    branchInst;
      logic    regWrt;
      regIdx_t wrtReg;
      word_t   wrtData;
   } commitTrace_t;

endpackage

// ==== design/stageRegister.sv ====
// Stallable pipeline register for any packed bundle type that sits at each stage boundary.

`timescale 1ns/1ps

module stageRegister #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     stall,
   input  payload_t d,
   output payload_t q
);

   // ==========================================================================
   // register
   // ==========================================================================

   // all-zero payload clears valid.
   always_ff @(posedge clk) begin
      if (reset) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

   // ==========================================================================
   // checks
   // ==========================================================================

   // a stalled edge must leave the bundle in place.
   holdOnStall : assert property (
      @(posedge clk) disable iff (reset)
      (stall && !reset) |=> $stable(q)
   ) else begin
      $error("stageRegister changed q after a stalled edge");
   end

endmodule

// ==== design/memoryStage.sv ====
// Memory stage with the data memory, one load or store per item, and the write-back bundle.

`timescale 1ns/1ps

module memoryStage (
   input  logic                     clk,
   input  logic                     stall,
   input  backendPkg::exMemBundle_t ex,
   output backendPkg::memWbBundle_t mw
);

   // ==========================================================================
   // data memory
   // ==========================================================================

   backendPkg::word_t dataMem [0:backendPkg::memWords-1];

   logic [backendPkg::memAddrBits-1:0] wordAddr;
   logic                               storeEn;
   backendPkg::word_t                  loadWord;

   // word address from the low alu bits.
   assign wordAddr = ex.aluFinal[backendPkg::memAddrBits-1:0];

   // held items must not store twice.
   assign storeEn = ex.valid && ex.memWrite && !stall;

   always_ff @(posedge clk) begin
      if (storeEn) begin
         dataMem[wordAddr] <= ex.storeData;
      end
   end

   // asynchronous read lets a load see the store before it.
   assign loadWord = dataMem[wordAddr];

   // ==========================================================================
   // bundle to write-back
   // ==========================================================================

   always_comb begin
      mw.valid       = ex.valid;
      mw.instruction = ex.instruction;
      mw.newPC       = ex.newPC;
      mw.branchInst  = ex.branchInst;
      mw.aluFinal    = ex.aluFinal;
      mw.memOut      = loadWord;
      mw.wbDataSel   = ex.wbDataSel;
      mw.addPC       = ex.addPC;
      mw.imm8        = ex.imm8;
      mw.regWrt      = ex.regWrt;
      mw.wrtReg      = ex.wrtReg;
   end

   // ==========================================================================
   // checks
   // ==========================================================================

   // execute must never issue a load and a store together.
   oneAccess : assert property (
      @(posedge clk)
      ex.valid |-> !(ex.memRead && ex.memWrite)
   ) else begin
      $error("memoryStage got memRead and memWrite in one valid item");
   end

endmodule

// ==== design/writebackRegisters.sv ====
// Write-back stage with source selection, the register file, bypassed reads and the commit trace.

`timescale 1ns/1ps

module writebackRegisters (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     stall,
   input  backendPkg::memWbBundle_t mw,
   input  backendPkg::regIdx_t      readAddrA,
   input  backendPkg::regIdx_t      readAddrB,
   output backendPkg::word_t        readDataA,
   output backendPkg::word_t        readDataB,
   output backendPkg::commitTrace_t commit
);

   backendPkg::word_t regFile [0:backendPkg::numRegs-1];
   backendPkg::word_t wrtData;
   logic              regWrtEn;

   // ==========================================================================
   // write data select
   // ==========================================================================

   always_comb begin
      case (mw.wbDataSel)
         backendPkg::wbSelMem: begin
            wrtData = mw.memOut;
         end
         backendPkg::wbSelAlu: begin
            wrtData = mw.aluFinal;
         end
         backendPkg::wbSelPc: begin
            wrtData = mw.addPC;
         end
         default: begin
            wrtData = mw.imm8;
         end
      endcase
   end

   // no write while the item is held.
   assign regWrtEn = mw.valid && mw.regWrt && !stall;

   // ==========================================================================
   // register file
   // ==========================================================================

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < backendPkg::numRegs; i++) begin
            regFile[i] <= '0;
         end
      end else if (regWrtEn) begin
         regFile[mw.wrtReg] <= wrtData;
      end
   end

   // write-through bypass on both ports.
   assign readDataA = (regWrtEn && (mw.wrtReg == readAddrA)) ? wrtData : regFile[readAddrA];
   assign readDataB = (regWrtEn && (mw.wrtReg == readAddrB)) ? wrtData : regFile[readAddrB];

   // ==========================================================================
   // commit trace
   // ==========================================================================

   // stays visible through a stall.
   always_comb begin
      commit.valid       = mw.valid;
      commit.instruction = mw.instruction;
      commit.newPC       = mw.newPC;
      commit.branchInst  = mw.branchInst;
      commit.regWrt      = mw.regWrt;
      commit.wrtReg      = mw.wrtReg;
      commit.wrtData     = wrtData;
   end

   // ==========================================================================
   // checks
   // ==========================================================================

   // bubbles from upstream carry no register write.
   cleanBubble : assert property (
      @(posedge clk) disable iff (reset)
      !commit.valid |-> !commit.regWrt
   ) else begin
      $error("writebackRegisters saw regWrt on an invalid commit");
   end

endmodule

// ==== design/memWbBackend.sv ====
// Top of the memory and write-back back end that chains both stage registers and stages.

`timescale 1ns/1ps

module memWbBackend (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     stall,
   input  backendPkg::exMemBundle_t exIn,
   input  backendPkg::regIdx_t      readAddrA,
   input  backendPkg::regIdx_t      readAddrB,
   output backendPkg::word_t        readDataA,
   output backendPkg::word_t        readDataB,
   output backendPkg::commitTrace_t commit
);

   backendPkg::exMemBundle_t exMem;
   backendPkg::memWbBundle_t memWbNext;
   backendPkg::memWbBundle_t memWb;

   // ==========================================================================
   // execute to memory
   // ==========================================================================

   stageRegister #(
      .payload_t (backendPkg::exMemBundle_t)
   ) exMemReg (
      .clk   (clk),
      .reset (reset),
      .stall (stall),
      .d     (exIn),
      .q     (exMem)
   );

   memoryStage memStage (
      .clk   (clk),
      .stall (stall),
      .ex    (exMem),
      .mw    (memWbNext)
   );

   // ==========================================================================
   // memory to write-back
   // ==========================================================================

   stageRegister #(
      .payload_t (backendPkg::memWbBundle_t)
   ) memWbReg (
      .clk   (clk),
      .reset (reset),
      .stall (stall),
      .d     (memWbNext),
      .q     (memWb)
   );

   writebackRegisters wbRegs (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),
      .mw        (memWb),
      .readAddrA (readAddrA),
      .readAddrB (readAddrB),
      .readDataA (readDataA),
      .readDataB (readDataB),
      .commit    (commit)
   );

endmodule

// ==== sim/memWbBackendTable.svh ====
// Stimulus table for the back-end testbench, included inside the testbench module.

// columns: kind, destination register, low word address, stall edges before capture.
// data words are drawn at run time, expected values come from the testbench model.

typedef enum logic [2:0] {
   opAlu,
   opStore,
   opLoad,
   opPc,
   opImm,
   opNoWrite
} opKind_t;

typedef struct packed {
   opKind_t             kind;
   backendPkg::regIdx_t dest;
   logic [7:0]          addr;
   logic [3:0]          stallCycles;
} stimRow_t;

localparam int numRows = 26;

localparam stimRow_t stimTable [0:numRows-1] = '{
   '{opAlu,     3'd1, 8'h00, 4'd0},
   '{opAlu,     3'd2, 8'h00, 4'd0},
   '{opAlu,     3'd1, 8'h00, 4'd0},
   '{opStore,   3'd0, 8'h10, 4'd0},
   '{opLoad,    3'd3, 8'h10, 4'd0},
   '{opStore,   3'd0, 8'h22, 4'd0},
   '{opLoad,    3'd4, 8'h10, 4'd0},
   '{opLoad,    3'd5, 8'h22, 4'd0},
   '{opPc,      3'd5, 8'h00, 4'd0},
   '{opImm,     3'd6, 8'h00, 4'd0},
   '{opNoWrite, 3'd6, 8'h00, 4'd0},
   '{opAlu,     3'd7, 8'h00, 4'd0},
   // stalls in the middle of the stream.
   '{opAlu,     3'd2, 8'h00, 4'd3},
   '{opStore,   3'd0, 8'h30, 4'd2},
   '{opStore,   3'd0, 8'h31, 4'd0},
   '{opAlu,     3'd3, 8'h00, 4'd1},
   '{opLoad,    3'd0, 8'h30, 4'd0},
   '{opLoad,    3'd7, 8'h31, 4'd0},
   // back to back.
   '{opImm,     3'd1, 8'h00, 4'd0},
   '{opPc,      3'd2, 8'h00, 4'd0},
   '{opAlu,     3'd4, 8'h00, 4'd0},
   '{opLoad,    3'd6, 8'h22, 4'd0},
   '{opNoWrite, 3'd4, 8'h00, 4'd0},
   '{opAlu,     3'd0, 8'h00, 4'd0},
   '{opStore,   3'd0, 8'h10, 4'd2},
   '{opLoad,    3'd3, 8'h10, 4'd0}
};

// ==== sim/memWbBackendTb.sv ====
// Testbench for the memory and write-back back end that runs from the Makefile via the file list.

`timescale 1ns/1ps

module memWbBackendTb;

   `include "memWbBackendTable.svh"

   localparam int watchdogCycles = 2000;
   localparam int drainLimit = 20;

   logic                     clk = 1'b0;
   logic                     reset;
   logic                     stall;
   backendPkg::exMemBundle_t exIn;
   backendPkg::regIdx_t      readAddrA;
   backendPkg::regIdx_t      readAddrB;
   backendPkg::word_t        readDataA;
   backendPkg::word_t        readDataB;
   backendPkg::commitTrace_t commit;

   // reference model state.
   backendPkg::word_t        memModel [0:backendPkg::memWords-1];
   backendPkg::word_t        regModel [0:backendPkg::numRegs-1];
   backendPkg::commitTrace_t expQ [$];
   int                       rowQ [$];
   int                       captureQ [$];
   backendPkg::commitTrace_t curExp;
   logic                     curValid = 1'b0;
   logic                     edgeFree = 1'b0;
   int                       freeEdges = 0;
   int                       errorCount = 0;
   int                       checkCount = 0;
   int                       rowIdx;
   int                       capEdge;
   int                       rowErrStart;
   int                       waited;
   backendPkg::word_t        expA;
   backendPkg::word_t        expB;
   backendPkg::exMemBundle_t item;
   backendPkg::commitTrace_t expItem;

   memWbBackend DUT (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),
      .exIn      (exIn),
      .readAddrA (readAddrA),
      .readAddrB (readAddrB),
      .readDataA (readDataA),
      .readDataB (readDataB),
      .commit    (commit)
   );

   always #5 clk = ~clk;

   // ==========================================================================
   // compare tasks and helpers
   // ==========================================================================

   task automatic checkCommit(input string name, input backendPkg::commitTrace_t got,
                              input backendPkg::commitTrace_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkWord(input string name, input backendPkg::word_t got,
                            input backendPkg::word_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   // destination of an earlier row or register 0 before the stream.
   function automatic backendPkg::regIdx_t destOf(input int r);
      if (r < 0) begin
         return '0;
      end
      return stimTable[r].dest;
   endfunction

   task automatic buildItem(input stimRow_t row, output backendPkg::exMemBundle_t it,
                            output backendPkg::commitTrace_t exp);
      backendPkg::word_t wrtData;
      it = '0;
      it.valid = 1'b1;
      it.instruction = backendPkg::word_t'($urandom);
      it.newPC = backendPkg::word_t'($urandom);
      it.branchInst = 1'($urandom);
      it.aluFinal = backendPkg::word_t'($urandom);
      it.storeData = backendPkg::word_t'($urandom);
      it.addPC = backendPkg::word_t'($urandom);
      it.imm8 = {8'h00, 8'($urandom)};
      it.wrtReg = row.dest;
      it.regWrt = 1'b1;
      it.wbDataSel = backendPkg::wbSelAlu;
      case (row.kind)
         opStore: begin
            it.aluFinal = {8'($urandom), row.addr};
            it.memWrite = 1'b1;
            it.regWrt = 1'b0;
            memModel[row.addr] = it.storeData;
         end
         opLoad: begin
            it.aluFinal = {8'($urandom), row.addr};
            it.memRead = 1'b1;
            it.wbDataSel = backendPkg::wbSelMem;
         end
         opPc: it.wbDataSel = backendPkg::wbSelPc;
         opImm: it.wbDataSel = backendPkg::wbSelImm;
         opNoWrite: it.regWrt = 1'b0;
         default: it.regWrt = 1'b1;
      endcase
      // selected source regardless of regWrt.
      case (it.wbDataSel)
         backendPkg::wbSelMem: wrtData = memModel[row.addr];
         backendPkg::wbSelPc: wrtData = it.addPC;
         backendPkg::wbSelImm: wrtData = it.imm8;
         default: wrtData = it.aluFinal;
      endcase
      exp = '{valid: 1'b1, instruction: it.instruction, newPC: it.newPC,
              branchInst: it.branchInst, regWrt: it.regWrt, wrtReg: it.wrtReg,
              wrtData: wrtData};
   endtask

   // ==========================================================================
   // monitor
   // ==========================================================================

   // stall and exIn read here are the values the edge used.
   always @(posedge clk) begin
      edgeFree = !reset && !stall;
      if (edgeFree) begin
         if (curValid && curExp.regWrt) begin
            regModel[curExp.wrtReg] = curExp.wrtData;
         end
         freeEdges++;
         if (exIn.valid) begin
            captureQ.push_back(freeEdges);
         end
      end
   end

   always @(negedge clk) begin
      if (!reset) begin
         if (edgeFree) begin
            curValid = 1'b0;
            if (commit.valid && expQ.size() == 0) begin
               errorCount++;
               $display("commit appeared with no item outstanding");
            end else if (commit.valid) begin
               rowErrStart = errorCount;
               curExp = expQ.pop_front();
               rowIdx = rowQ.pop_front();
               capEdge = (captureQ.size() != 0) ? captureQ.pop_front() : -10;
               curValid = 1'b1;
               checkCommit("commit", commit, curExp);
               if (freeEdges != capEdge + 1) begin
                  errorCount++;
                  $display("row %0d committed on the wrong cycle", rowIdx);
               end
               $display("row %0d %s done, %0d errors", rowIdx,
                        stimTable[rowIdx].kind.name(), errorCount - rowErrStart);
            end
         end else if (curValid) begin
            // held through a stalled edge.
            checkCommit("commit", commit, curExp);
         end else if (commit.valid) begin
            errorCount++;
            $display("commit turned valid on a stalled edge");
         end
         expA = (curValid && curExp.regWrt && !stall && curExp.wrtReg == readAddrA) ?
                curExp.wrtData : regModel[readAddrA];
         expB = (curValid && curExp.regWrt && !stall && curExp.wrtReg == readAddrB) ?
                curExp.wrtData : regModel[readAddrB];
         checkWord("readDataA", readDataA, expA);
         checkWord("readDataB", readDataB, expB);
      end
   end

   // ==========================================================================
   // stimulus
   // ==========================================================================

   initial begin
      void'($urandom(32'h890a));
      reset = 1'b1;
      stall = 1'b0;
      exIn = '0;
      readAddrA = '0;
      readAddrB = '0;
      for (int i = 0; i < backendPkg::numRegs; i++) begin
         regModel[i] = '0;
      end
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      // every register reads zero after reset.
      for (int i = 0; i < backendPkg::numRegs; i++) begin
         @(posedge clk);
         readAddrA <= backendPkg::regIdx_t'(i);
         readAddrB <= backendPkg::regIdx_t'(backendPkg::numRegs - 1 - i);
      end
      @(posedge clk);
      $display("post-reset sweep done, %0d errors", errorCount);
      for (int r = 0; r < numRows; r++) begin
         buildItem(stimTable[r], item, expItem);
         expQ.push_back(expItem);
         rowQ.push_back(r);
         // port A reads the committing row and port B the one before it.
         for (int j = 0; j <= stimTable[r].stallCycles; j++) begin
            if (j != 0) begin
               @(posedge clk);
            end
            exIn <= item;
            stall <= (j < stimTable[r].stallCycles);
            readAddrA <= destOf(r - 2);
            readAddrB <= destOf(r - 3);
         end
         @(posedge clk);
      end
      exIn <= '0;
      stall <= 1'b0;
      waited = 0;
      while (expQ.size() != 0 && waited < drainLimit) begin
         @(posedge clk);
         waited++;
      end
      if (expQ.size() != 0) begin
         errorCount++;
         $display("timeout while draining, %0d items never committed", expQ.size());
      end
      @(posedge clk);
      @(negedge clk);
      $display("rows %0d, checks %0d, errors %0d", numRows, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      for (int c = 0; c < watchdogCycles; c++) begin
         @(posedge clk);
      end
      $display("timeout, the run went past %0d cycles", watchdogCycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== memWbBackend.f ====
+incdir+sim
design/backendPkg.sv
design/stageRegister.sv
design/memoryStage.sv
design/writebackRegisters.sv
design/memWbBackend.sv
sim/memWbBackendTb.sv

// ==== Makefile ====
# Verilator build for the memory and write-back back end.

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= memWbBackendTb
FILELIST   ?= memWbBackend.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass or fail is taken from the log.
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
